// File: tb.f
logic/cache_pkg.sv
logic/cache_way.sv
logic/write_buffer.sv
logic/cache_ctrl.sv
logic/cache_top.sv
tb/cache_chk.sv
tb/cache_tb.sv

// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := cache_tb
FILELIST := tb.f
OBJ_DIR  := obj_dir
LOG      := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TB FAILED" $(LOG) || ! grep -q "TB PASSED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb/cache_tb.sv
`timescale 1ns/100ps

module cache_tb;

    localparam int          TIMEOUT = 200;            // cycles allowed per wait
    localparam logic [31:0] SEED    = 32'h4022_9afb;

    logic                clk;
    logic                reset;
    logic                valid;
    cache_pkg::cpu_req_t req;
    logic                addr_ok;
    logic                data_ok;
    logic [31:0]         rdata;
    logic                rd_req;
    logic [31:0]         rd_addr;
    logic                rd_rdy;
    logic                ret_valid;
    logic                ret_last;
    logic [31:0]         ret_data;
    logic                wr_req;
    logic [31:0]         wr_addr;
    cache_pkg::line_t    wr_data;
    logic                wr_rdy;

    cache_pkg::line_t backing [bit [27:0]];   // memory behind the cache
    cache_pkg::line_t golden [bit [27:0]];    // what the cpu should see

    logic [31:0] stim_lfsr;
    logic [31:0] mem_lfsr;
    logic [31:0] pending_line;     // line of the last accepted request
    logic [27:0] watch_line;
    logic        watch_evicted;
    logic        hung;
    int          errors;
    int          checks;
    int          tests_run;
    int          tests_failed;

    cache_top cache_top_inst (
        .clk       (clk),
        .reset     (reset),
        .valid     (valid),
        .req       (req),
        .addr_ok   (addr_ok),
        .data_ok   (data_ok),
        .rdata     (rdata),
        .rd_req    (rd_req),
        .rd_addr   (rd_addr),
        .rd_rdy    (rd_rdy),
        .ret_valid (ret_valid),
        .ret_last  (ret_last),
        .ret_data  (ret_data),
        .wr_req    (wr_req),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .wr_rdy    (wr_rdy)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(inout logic [31:0] st, input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            st = lfsr_step(st);
            val = {val[30:0], st[0]};
        end
    endtask

    function automatic logic [31:0] fill_word(input logic [31:0] a);
        return a ^ {a[15:0], a[31:16]} ^ 32'hc3a5_5a3c;
    endfunction

    // 4 tags on 4 sets, so lines keep fighting for 2 ways
    function automatic logic [31:0] make_addr(input logic [1:0] tsel, input logic [1:0] isel,
                                              input logic [1:0] word);
        logic [19:0] tag;
        case (tsel)
            2'd0:    tag = 20'h0_0a31;
            2'd1:    tag = 20'h1_2f40;
            2'd2:    tag = 20'h8_00c7;
            default: tag = 20'hf_ff12;
        endcase
        return {tag, isel, 6'h15, word, 2'b00};
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] wd,
                                                input logic [3:0] strb);
        logic [31:0] m;
        m = old;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                m[8*b +: 8] = wd[8*b +: 8];
            end
        end
        return m;
    endfunction

    function automatic logic [31:0] golden_word(input logic [31:0] a);
        cache_pkg::line_t ln;
        ln = golden[a[31:4]];
        return ln[a[3:2]];
    endfunction

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_line(input string name, input cache_pkg::line_t got,
                              input cache_pkg::line_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s got %h expected %h", name, got, exp);
        end
    endtask

    // one cpu request, returns read data and cycles from acceptance to data_ok
    task automatic cpu_access(input logic op, input logic [31:0] a, input logic [3:0] strb,
                              input logic [31:0] wd, output logic [31:0] rd, output int lat);
        cache_pkg::cpu_req_t r;
        cache_pkg::line_t    ln;
        int                  waited;
        rd = '0;
        lat = 0;
        if (hung) begin
            return;
        end
        r = '{op: op, index: a[11:4], tag: a[31:12], offset: a[3:0], wstrb: strb, wdata: wd};
        valid <= 1'b1;
        req   <= r;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
        end while (!addr_ok && waited < TIMEOUT);
        valid <= 1'b0;
        if (!addr_ok) begin
            errors++;
            hung = 1'b1;
            $display("timeout waiting for addr_ok, request at %h never accepted", a);
            return;
        end
        pending_line = {a[31:4], 4'h0};
        if (op) begin
            ln = golden[a[31:4]];
            ln[a[3:2]] = merge_bytes(ln[a[3:2]], wd, strb);
            golden[a[31:4]] = ln;
        end
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
        end while (!data_ok && waited < TIMEOUT);
        if (!data_ok) begin
            errors++;
            hung = 1'b1;
            $display("timeout waiting for data_ok on request at %h", a);
            return;
        end
        rd = rdata;
        lat = waited;
    endtask

    task automatic serve_writeback();
        logic [31:0] d;
        logic [27:0] key;
        take_bits(mem_lfsr, 2, d);
        repeat (d) @(posedge clk);
        wr_rdy <= 1'b1;
        @(posedge clk);    // write taken on this edge
        wr_rdy <= 1'b0;
        // victim sits in the missing request's set
        check_addr("wr_addr", {20'h0, wr_addr[11:0]}, {20'h0, pending_line[11:0]});
        key = wr_addr[31:4];
        if (!golden.exists(key)) begin
            errors++;
            $display("writeback to an address never used: %h", wr_addr);
        end else begin
            check_line("wr_data", wr_data, golden[key]);
            backing[key] = wr_data;
            if (key == watch_line) begin
                watch_evicted = 1'b1;
            end
        end
    endtask

    task automatic serve_refill();
        logic [31:0]      d;
        cache_pkg::line_t ln;
        take_bits(mem_lfsr, 2, d);
        repeat (d) @(posedge clk);
        rd_rdy <= 1'b1;
        @(posedge clk);
        rd_rdy <= 1'b0;
        check_addr("rd_addr", rd_addr, pending_line);
        ln = '0;
        if (backing.exists(rd_addr[31:4])) begin
            ln = backing[rd_addr[31:4]];
        end else begin
            errors++;
            $display("refill from an address never used: %h", rd_addr);
        end
        for (int k = 0; k < 4; k++) begin
            take_bits(mem_lfsr, 2, d);
            repeat (d) begin
                ret_valid <= 1'b0;
                @(posedge clk);
            end
            ret_valid <= 1'b1;
            ret_last  <= (k == 3);
            ret_data  <= ln[k];
            @(posedge clk);
        end
        ret_valid <= 1'b0;
        ret_last  <= 1'b0;
    endtask

    // memory side, one transfer at a time
    initial begin
        forever begin
            @(posedge clk);
            if (!reset && wr_req) begin
                serve_writeback();
            end else if (!reset && rd_req) begin
                serve_refill();
            end
        end
    end

    task automatic rand_addr(output logic [31:0] a);
        logic [31:0] t;
        logic [31:0] i;
        logic [31:0] w;
        take_bits(stim_lfsr, 2, t);
        take_bits(stim_lfsr, 2, i);
        take_bits(stim_lfsr, 2, w);
        a = make_addr(t[1:0], i[1:0], w[1:0]);
    endtask

    task automatic report_test(input string name, input int err0);
        tests_run++;
        if (errors == err0) begin
            $display("test %s ok", name);
        end else begin
            tests_failed++;
            $display("test %s failed with %0d errors", name, errors - err0);
        end
    endtask

    task automatic test_random_mix();
        logic [31:0] a;
        logic [31:0] op;
        logic [31:0] strb;
        logic [31:0] wd;
        logic [31:0] exp;
        logic [31:0] rd;
        int          lat;
        int          err0;
        err0 = errors;
        for (int n = 0; n < 200; n++) begin
            rand_addr(a);
            take_bits(stim_lfsr, 1, op);
            take_bits(stim_lfsr, 4, strb);
            take_bits(stim_lfsr, 32, wd);
            exp = golden_word(a);
            cpu_access(op[0], a, strb[3:0], wd, rd, lat);
            if (!op[0] && !hung) begin
                check_word("rdata", rd, exp);
            end
        end
        report_test("random_mix", err0);
    endtask

    task automatic test_write_read();
        logic [31:0] a;
        logic [31:0] strb;
        logic [31:0] wd;
        logic [31:0] exp;
        logic [31:0] rd;
        int          lat;
        int          err0;
        err0 = errors;
        for (int n = 0; n < 16; n++) begin
            rand_addr(a);
            take_bits(stim_lfsr, 4, strb);
            take_bits(stim_lfsr, 32, wd);
            exp = merge_bytes(golden_word(a), wd, strb[3:0]);
            cpu_access(1'b1, a, strb[3:0], wd, rd, lat);
            cpu_access(1'b0, a, 4'h0, 32'h0, rd, lat);
            check_word("rdata", rd, exp);
        end
        report_test("write_read", err0);
    endtask

    task automatic test_hit_latency();
        logic [31:0] a;
        logic [31:0] rd;
        int          lat;
        int          err0;
        err0 = errors;
        for (int n = 0; n < 16; n++) begin
            rand_addr(a);
            cpu_access(1'b0, a, 4'h0, 32'h0, rd, lat);
            check_word("rdata", rd, golden_word(a));
            cpu_access(1'b0, a, 4'h0, 32'h0, rd, lat);
            check_word("rdata", rd, golden_word(a));
            if (lat != 1) begin
                errors++;
                $display("repeat read at %h took %0d cycles instead of 1", a, lat);
            end
        end
        report_test("hit_latency", err0);
    endtask

    task automatic test_dirty_eviction();
        logic [31:0] a;
        logic [31:0] other;
        logic [31:0] wd;
        logic [31:0] rd;
        int          lat;
        int          err0;
        int          n;
        err0 = errors;
        for (int isel = 0; isel < 4; isel++) begin
            a = make_addr(2'd0, isel[1:0], 2'd2);
            take_bits(stim_lfsr, 32, wd);
            cpu_access(1'b1, a, 4'hf, wd, rd, lat);
            watch_line = a[31:4];
            watch_evicted = 1'b0;
            n = 0;
            // other tags in the same set until the dirty line leaves
            while (!watch_evicted && !hung && n < 12) begin
                other = make_addr(2'(n % 3 + 1), isel[1:0], 2'd0);
                cpu_access(1'b0, other, 4'h0, 32'h0, rd, lat);
                check_word("rdata", rd, golden_word(other));
                n++;
            end
            if (!watch_evicted) begin
                errors++;
                $display("dirty line at %h was never written back", a);
            end
            cpu_access(1'b0, a, 4'h0, 32'h0, rd, lat);
            check_word("rdata", rd, wd);
        end
        report_test("dirty_eviction", err0);
    endtask

    initial begin
        cache_pkg::line_t ln;
        logic [31:0]      a;
        int               err0;
        reset = 1'b1;
        valid = 1'b0;
        req = '0;
        rd_rdy = 1'b0;
        ret_valid = 1'b0;
        ret_last = 1'b0;
        ret_data = '0;
        wr_rdy = 1'b0;
        stim_lfsr = SEED;
        mem_lfsr = SEED;
        pending_line = '0;
        watch_line = '1;
        watch_evicted = 1'b0;
        hung = 1'b0;
        errors = 0;
        checks = 0;
        tests_run = 0;
        tests_failed = 0;
        for (int t = 0; t < 4; t++) begin
            for (int i = 0; i < 4; i++) begin
                for (int w = 0; w < 4; w++) begin
                    a = make_addr(t[1:0], i[1:0], w[1:0]);
                    ln[w] = fill_word(a);
                end
                backing[a[31:4]] = ln;
                golden[a[31:4]] = ln;
            end
        end
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        err0 = errors;
        check_flag("addr_ok", addr_ok, 1'b1);
        check_flag("data_ok", data_ok, 1'b0);
        check_flag("rd_req", rd_req, 1'b0);
        check_flag("wr_req", wr_req, 1'b0);
        report_test("reset_state", err0);
        test_random_mix();
        test_write_read();
        test_hit_latency();
        test_dirty_eviction();
        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: tb/cache_chk.sv
`timescale 1ns/100ps

module cache_chk (
    input logic clk,
    input logic reset,
    input logic addr_ok,
    input logic data_ok,
    input logic rd_req,
    input logic rd_rdy,
    input logic wr_req,
    input logic wr_rdy
);

    // one memory channel busy at a time
    req_exclusive: assert property (@(posedge clk) disable iff (reset) !(rd_req && wr_req))
        else $error("rd_req and wr_req high in the same cycle");

    // data_ok only comes from LOOKUP or REFILL
    cpu_exclusive: assert property (@(posedge clk) disable iff (reset) !(addr_ok && data_ok))
        else $error("addr_ok and data_ok high in the same cycle");

    wr_hold: assert property (@(posedge clk) disable iff (reset) wr_req && !wr_rdy |=> wr_req)
        else $error("wr_req dropped before wr_rdy");

    rd_hold: assert property (@(posedge clk) disable iff (reset) rd_req && !rd_rdy |=> rd_req)
        else $error("rd_req dropped before rd_rdy");

endmodule

bind cache_ctrl cache_chk cache_chk_inst (
    .clk     (clk),
    .reset   (reset),
    .addr_ok (addr_ok),
    .data_ok (data_ok),
    .rd_req  (rd_req),
    .rd_rdy  (rd_rdy),
    .wr_req  (wr_req),
    .wr_rdy  (wr_rdy)
);

// File: logic/cache_top.sv
`timescale 1ns/100ps

module cache_top (
    input  logic                clk,
    input  logic                reset,
    input  logic                valid,
    input  cache_pkg::cpu_req_t req,
    output logic                addr_ok,
    output logic                data_ok,
    output logic [31:0]         rdata,
    output logic                rd_req,
    output logic [31:0]         rd_addr,
    input  logic                rd_rdy,
    input  logic                ret_valid,
    input  logic                ret_last,
    input  logic [31:0]         ret_data,
    output logic                wr_req,
    output logic [31:0]         wr_addr,
    output cache_pkg::line_t    wr_data,
    input  logic                wr_rdy
);

    cache_pkg::way_port_t way_cmd0;
    cache_pkg::way_port_t way_cmd1;
    cache_pkg::tagv_t     way_tagv0;
    cache_pkg::tagv_t     way_tagv1;
    cache_pkg::line_t     way_line0;
    cache_pkg::line_t     way_line1;
    cache_pkg::wbuf_t     wbuf;
    cache_pkg::wbuf_t     wbuf_next;
    logic                 wbuf_load;

    cache_ctrl cache_ctrl_inst (
        .clk       (clk),
        .reset     (reset),
        .valid     (valid),
        .req       (req),
        .addr_ok   (addr_ok),
        .data_ok   (data_ok),
        .rdata     (rdata),
        .rd_req    (rd_req),
        .rd_addr   (rd_addr),
        .rd_rdy    (rd_rdy),
        .ret_valid (ret_valid),
        .ret_last  (ret_last),
        .ret_data  (ret_data),
        .wr_req    (wr_req),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .wr_rdy    (wr_rdy),
        .way_cmd0  (way_cmd0),
        .way_cmd1  (way_cmd1),
        .way_tagv0 (way_tagv0),
        .way_tagv1 (way_tagv1),
        .way_line0 (way_line0),
        .way_line1 (way_line1),
        .wbuf      (wbuf),
        .wbuf_load (wbuf_load),
        .wbuf_next (wbuf_next)
    );

    write_buffer write_buffer_inst (
        .clk   (clk),
        .reset (reset),
        .load  (wbuf_load),
        .next  (wbuf_next),
        .wbuf  (wbuf)
    );

    cache_way way0_inst (
        .clk   (clk),
        .reset (reset),
        .cmd   (way_cmd0),
        .tagv  (way_tagv0),
        .line  (way_line0)
    );

    cache_way way1_inst (
        .clk   (clk),
        .reset (reset),
        .cmd   (way_cmd1),
        .tagv  (way_tagv1),
        .line  (way_line1)
    );

endmodule

// File: logic/cache_ctrl.sv
`timescale 1ns/100ps

module cache_ctrl (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 valid,
    input  cache_pkg::cpu_req_t  req,
    output logic                 addr_ok,
    output logic                 data_ok,
    output logic [31:0]          rdata,
    output logic                 rd_req,
    output logic [31:0]          rd_addr,
    input  logic                 rd_rdy,
    input  logic                 ret_valid,
    input  logic                 ret_last,
    input  logic [31:0]          ret_data,
    output logic                 wr_req,
    output logic [31:0]          wr_addr,
    output cache_pkg::line_t     wr_data,
    input  logic                 wr_rdy,
    output cache_pkg::way_port_t way_cmd0,
    output cache_pkg::way_port_t way_cmd1,
    input  cache_pkg::tagv_t     way_tagv0,
    input  cache_pkg::tagv_t     way_tagv1,
    input  cache_pkg::line_t     way_line0,
    input  cache_pkg::line_t     way_line1,
    input  cache_pkg::wbuf_t     wbuf,
    output logic                 wbuf_load,
    output cache_pkg::wbuf_t     wbuf_next
);

    cache_pkg::state_t    state;
    cache_pkg::state_t    state_next;
    cache_pkg::cpu_req_t  req_q;         // request buffer
    cache_pkg::tagv_t     tagv [2];
    cache_pkg::line_t     line [2];
    cache_pkg::way_port_t cmd [2];

    logic [cache_pkg::SETS-1:0]   dirty [2];
    logic [2:0]                   lfsr;
    logic [cache_pkg::BANK_W-1:0] refill_cnt;
    logic [cache_pkg::BANK_W-1:0] req_bank;
    logic [31:0]                  refill_word;

    logic accept;
    logic hit0;
    logic hit1;
    logic hit;
    logic victim;
    logic victim_dirty;
    logic refill_wr;

    assign tagv[0] = way_tagv0;
    assign tagv[1] = way_tagv1;
    assign line[0] = way_line0;
    assign line[1] = way_line1;

    assign way_cmd0 = cmd[0];
    assign way_cmd1 = cmd[1];

    // new request only while the RAM port is free
    assign addr_ok = (state == cache_pkg::IDLE) && !wbuf.busy;
    assign accept  = valid && addr_ok;

    assign req_bank = req_q.offset[cache_pkg::OFFSET_W-1 -: cache_pkg::BANK_W];

    // tag compare, ram outputs hold from the lookup read
    assign hit0 = tagv[0].valid && (tagv[0].tag == req_q.tag);
    assign hit1 = tagv[1].valid && (tagv[1].tag == req_q.tag);
    assign hit  = hit0 || hit1;

    assign victim       = lfsr[0];
    assign victim_dirty = tagv[victim].valid && dirty[victim][req_q.index];

    assign refill_wr = (state == cache_pkg::REFILL) && ret_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= cache_pkg::IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            cache_pkg::IDLE: begin
                if (accept) begin
                    state_next = cache_pkg::LOOKUP;
                end
            end
            cache_pkg::LOOKUP: begin
                state_next = hit ? cache_pkg::IDLE : cache_pkg::MISS;
            end
            cache_pkg::MISS: begin
                // clean victim skips the writeback
                if (!victim_dirty || wr_rdy) begin
                    state_next = cache_pkg::REPLACE;
                end
            end
            cache_pkg::REPLACE: begin
                if (rd_rdy) begin
                    state_next = cache_pkg::REFILL;
                end
            end
            cache_pkg::REFILL: begin
                if (ret_valid && ret_last) begin
                    state_next = cache_pkg::IDLE;
                end
            end
            default: state_next = cache_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= req;
        end
    end

    // word counter for the incoming refill beats
    always_ff @(posedge clk) begin
        if (reset) begin
            refill_cnt <= '0;
        end else if (refill_wr) begin
            refill_cnt <= refill_cnt + 1'b1;     // wraps back to 0 after word 3
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            lfsr <= cache_pkg::LFSR_INIT;
        end else if (refill_wr && ret_last) begin
            lfsr <= {lfsr[1:0], lfsr[2] ^ lfsr[1]};
        end
    end

    // dirty tables, a write miss leaves the refilled line dirty
    always_ff @(posedge clk) begin
        if (reset) begin
            dirty[0] <= '0;
            dirty[1] <= '0;
        end else if (wbuf.busy) begin
            dirty[wbuf.way][wbuf.index] <= 1'b1;
        end else if (refill_wr) begin
            dirty[victim][req_q.index] <= req_q.op;
        end
    end

    // merge store bytes into the requested word on a write miss
    always_comb begin
        refill_word = ret_data;
        if (req_q.op && (refill_cnt == req_bank)) begin
            for (int b = 0; b < 4; b++) begin
                if (req_q.wstrb[b]) begin
                    refill_word[8*b +: 8] = req_q.wdata[8*b +: 8];
                end
            end
        end
    end

    // ram port per way: refill, then write buffer, then lookup
    always_comb begin
        for (int w = 0; w < 2; w++) begin
            cmd[w] = '0;
            if (state == cache_pkg::REFILL) begin
                cmd[w].addr       = req_q.index;
                cmd[w].tagv_wdata = '{tag: req_q.tag, valid: 1'b1};
                cmd[w].wdata      = refill_word;
                if (ret_valid && (victim == w[0])) begin
                    cmd[w].bank_en[refill_cnt] = 1'b1;
                    cmd[w].bank_we[refill_cnt] = 4'hf;
                    if (refill_cnt == req_bank) begin
                        cmd[w].tagv_en = 1'b1;   // tag goes in with the critical word
                        cmd[w].tagv_we = 1'b1;
                    end
                end
            end else if (wbuf.busy) begin
                cmd[w].addr  = wbuf.index;
                cmd[w].wdata = wbuf.data;
                if (wbuf.way == w[0]) begin
                    cmd[w].bank_en[wbuf.bank] = 1'b1;
                    cmd[w].bank_we[wbuf.bank] = wbuf.strb;
                end
            end else begin
                // read every bank so a victim line is ready in MISS
                cmd[w].addr    = req.index;
                cmd[w].tagv_en = accept;
                cmd[w].bank_en = {cache_pkg::WORDS{accept}};
            end
        end
    end

    assign wbuf_load = (state == cache_pkg::LOOKUP) && req_q.op && hit;
    assign wbuf_next = '{
        busy:  1'b1,
        way:   hit1,
        bank:  req_bank,
        index: req_q.index,
        strb:  req_q.wstrb,
        data:  req_q.wdata
    };

    assign data_ok = ((state == cache_pkg::LOOKUP) && (hit || req_q.op))
                   || (refill_wr && !req_q.op && (refill_cnt == req_bank));

    assign rdata = (state == cache_pkg::REFILL) ? ret_data : line[hit1][req_bank];

    assign rd_req  = (state == cache_pkg::REPLACE);
    assign rd_addr = {req_q.tag, req_q.index, {cache_pkg::OFFSET_W{1'b0}}};

    assign wr_req  = (state == cache_pkg::MISS) && victim_dirty;
    assign wr_addr = {tagv[victim].tag, req_q.index, {cache_pkg::OFFSET_W{1'b0}}};
    assign wr_data = line[victim];

endmodule

// File: logic/write_buffer.sv
`timescale 1ns/100ps

module write_buffer (
    input  logic             clk,
    input  logic             reset,
    input  logic             load,
    input  cache_pkg::wbuf_t next,
    output cache_pkg::wbuf_t wbuf
);

    typedef enum logic [1:0] {
        WB_IDLE  = 2'b01,
        WB_WRITE = 2'b10
    } wb_state_t;

    wb_state_t state;
    wb_state_t state_next;

    logic                          way_q;
    logic [cache_pkg::BANK_W-1:0]  bank_q;
    logic [cache_pkg::INDEX_W-1:0] index_q;
    logic [3:0]                    strb_q;
    logic [31:0]                   data_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= WB_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // busy the cycle after a load, back to back hits stay busy
    assign state_next = load ? WB_WRITE : WB_IDLE;

    // hit data waits here for its ram cycle
    always_ff @(posedge clk) begin
        if (load) begin
            way_q   <= next.way;
            bank_q  <= next.bank;
            index_q <= next.index;
            strb_q  <= next.strb;
            data_q  <= next.data;
        end
    end

    assign wbuf = '{
        busy:  state == WB_WRITE,
        way:   way_q,
        bank:  bank_q,
        index: index_q,
        strb:  strb_q,
        data:  data_q
    };

endmodule

// File: logic/cache_way.sv
`timescale 1ns/100ps

module cache_way (
    input  logic                 clk,
    input  logic                 reset,
    input  cache_pkg::way_port_t cmd,
    output cache_pkg::tagv_t     tagv,
    output cache_pkg::line_t     line
);

    logic [cache_pkg::TAG_W-1:0] tag_ram [cache_pkg::SETS];
    logic [cache_pkg::SETS-1:0]  valid_vec;   // per-set valid, cleared on reset
    logic [cache_pkg::TAG_W-1:0] tag_q;
    logic                        valid_q;

    // tag ram, read-first
    always_ff @(posedge clk) begin
        if (cmd.tagv_en) begin
            tag_q   <= tag_ram[cmd.addr];
            valid_q <= valid_vec[cmd.addr];
            if (cmd.tagv_we) begin
                tag_ram[cmd.addr] <= cmd.tagv_wdata.tag;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_vec <= '0;
        end else if (cmd.tagv_en && cmd.tagv_we) begin
            valid_vec[cmd.addr] <= cmd.tagv_wdata.valid;
        end
    end

    assign tagv = '{tag: tag_q, valid: valid_q};

    // one single-port bank per word of the line
    for (genvar b = 0; b < cache_pkg::WORDS; b++) begin : g_bank
        logic [31:0] mem [cache_pkg::SETS];
        logic [31:0] rdata_q;

        always_ff @(posedge clk) begin
            if (cmd.bank_en[b]) begin
                rdata_q <= mem[cmd.addr];            // old word out on a write
                for (int i = 0; i < 4; i++) begin
                    if (cmd.bank_we[b][i]) begin
                        mem[cmd.addr][8*i +: 8] <= cmd.wdata[8*i +: 8];
                    end
                end
            end
        end

        assign line[b] = rdata_q;
    end

endmodule

// File: logic/cache_pkg.sv
package cache_pkg;

    // address split: tag | index | offset
    localparam int TAG_W    = 20;
    localparam int INDEX_W  = 8;
    localparam int OFFSET_W = 4;

    localparam int WORDS  = 4;    // words per line
    localparam int BANK_W = 2;    // word select
    localparam int SETS   = 256;

    localparam logic [2:0] LFSR_INIT = 3'b111;

    // main FSM, one-hot
    typedef enum logic [4:0] {
        IDLE    = 5'b00001,
        LOOKUP  = 5'b00010,
        MISS    = 5'b00100,
        REPLACE = 5'b01000,
        REFILL  = 5'b10000
    } state_t;

    typedef struct packed {
        logic                op;        // 0 read, 1 write
        logic [INDEX_W-1:0]  index;
        logic [TAG_W-1:0]    tag;
        logic [OFFSET_W-1:0] offset;
        logic [3:0]          wstrb;
        logic [31:0]         wdata;
    } cpu_req_t;

    typedef struct packed {
        logic [TAG_W-1:0] tag;
        logic             valid;
    } tagv_t;

    // word 0 sits in the low bits
    typedef logic [WORDS-1:0][31:0] line_t;

    typedef struct packed {
        logic               busy;
        logic               way;
        logic [BANK_W-1:0]  bank;
        logic [INDEX_W-1:0] index;
        logic [3:0]         strb;
        logic [31:0]        data;
    } wbuf_t;

    typedef struct packed {
        logic [INDEX_W-1:0]      addr;
        logic                    tagv_en;
        logic                    tagv_we;
        tagv_t                   tagv_wdata;
        logic [WORDS-1:0]        bank_en;
        logic [WORDS-1:0][3:0]   bank_we;   // byte enables per bank
        logic [31:0]             wdata;
    } way_port_t;

endpackage
